// File: hw/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Virtual and physical address width.
`define MMU_ADDR_W 32

// Address error exception code.
`define MMU_ECODE_ADE 6'h08

// Address error subcodes.
// ADEF is a bad fetch address, ADEM a bad load/store address.
`define MMU_ESUB_ADEF 9'h000
`define MMU_ESUB_ADEM 9'h001

// Request ports: fetch and load/store.
`define MMU_PORTS 2

`endif

// File: hw/mmuPkg.sv
package mmuPkg;

    // Operation carried by a translation request.
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } opType_e;

    // Mapping register selected by a CSR write.
    typedef enum logic [1:0] {
        CRMD = 2'd0,
        ASID = 2'd1,
        DMW0 = 2'd2,
        DMW1 = 2'd3
    } csrSel_e;

    // Exception recorder state.
    typedef enum logic {
        IDLE = 1'b0,
        HELD = 1'b1
    } recState_e;

endpackage

// File: hw/mapCsrRegs.sv
`timescale 1ns/1ns
`include "mmu_defs.svh"

module mapCsrRegs (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   csrWe,
    input  mmuPkg::csrSel_e        csrSel,
    input  logic [`MMU_ADDR_W-1:0] csrWdata,
    output logic [8:0]             crmd,
    output logic [9:0]             asid,
    output logic [`MMU_ADDR_W-1:0] dmw0,
    output logic [`MMU_ADDR_W-1:0] dmw1,
    output logic                   dmw0Ok,
    output logic                   dmw1Ok
);

    // VSEG, PSEG, MAT, PLV3 and PLV0 of a window.
    localparam logic [`MMU_ADDR_W-1:0] dmwMask = 32'hEE00_0039;

    function automatic logic plvOk(
        input logic [`MMU_ADDR_W-1:0] dmw,
        input logic [1:0]             plv
    );
        plvOk = (dmw[0] && plv == 2'd0) || (dmw[3] && plv == 2'd3);
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            crmd <= '0;
            asid <= '0;
            dmw0 <= '0;
            dmw1 <= '0;
        end
        else if (csrWe)
        begin
            case (csrSel)
                mmuPkg::CRMD: crmd <= csrWdata[8:0];
                mmuPkg::ASID: asid <= csrWdata[9:0];
                mmuPkg::DMW0: dmw0 <= csrWdata & dmwMask;
                mmuPkg::DMW1: dmw1 <= csrWdata & dmwMask;
            endcase
        end
    end

    // Shared by both request ports.
    assign dmw0Ok = plvOk(dmw0, crmd[1:0]);
    assign dmw1Ok = plvOk(dmw1, crmd[1:0]);

    // DA and PG together is not a legal mode.
    crmdModeLegal: assert property (
        @(posedge clk) disable iff (!rstN)
        (csrWe && csrSel == mmuPkg::CRMD) |=> (crmd[4:3] != 2'b11)
    ) else $error("crmd written with DA and PG both set");

endmodule

// File: hw/addrTranslator.sv
`timescale 1ns/1ns
`include "mmu_defs.svh"

module addrTranslator (
    input  logic [8:0]             crmd,
    input  logic [`MMU_ADDR_W-1:0] dmw0,
    input  logic [`MMU_ADDR_W-1:0] dmw1,
    input  logic                   dmw0Ok,
    input  logic                   dmw1Ok,
    input  logic [`MMU_PORTS-1:0]  reqValid,
    input  logic [`MMU_PORTS-1:0]  reqFlush,
    input  mmuPkg::opType_e        reqOp0,
    input  mmuPkg::opType_e        reqOp1,
    input  logic [`MMU_ADDR_W-1:0] reqVaddr0,
    input  logic [`MMU_ADDR_W-1:0] reqVaddr1,
    output logic [`MMU_ADDR_W-1:0] rawPaddr0,
    output logic [`MMU_ADDR_W-1:0] rawPaddr1,
    output logic [1:0]             rawMemType0,
    output logic [1:0]             rawMemType1,
    output logic [`MMU_PORTS-1:0]  rawExcp,
    output logic [5:0]             rawEcode0,
    output logic [5:0]             rawEcode1,
    output logic [8:0]             rawEsub0,
    output logic [8:0]             rawEsub1
);

    function automatic void mapOne(
        input  logic                   valid,
        input  logic                   flush,
        input  mmuPkg::opType_e        op,
        input  logic [`MMU_ADDR_W-1:0] vaddr,
        output logic [`MMU_ADDR_W-1:0] paddr,
        output logic [1:0]             memType,
        output logic                   excp,
        output logic [5:0]             ecode,
        output logic [8:0]             esub
    );
        paddr   = '0;
        memType = 2'd0;
        excp    = 1'b0;
        ecode   = 6'd0;
        esub    = 9'd0;
        if (!flush)
        begin
            // Direct address mode.
            if (crmd[4:3] == 2'b01)
            begin
                paddr   = vaddr;
                memType = (op == mmuPkg::FETCH) ? crmd[6:5] : crmd[8:7];
            end
            else if (dmw0Ok && dmw0[31:29] == vaddr[31:29])
            begin
                paddr   = {dmw0[27:25], vaddr[28:0]};
                memType = dmw0[5:4];
            end
            else if (dmw1Ok && dmw1[31:29] == vaddr[31:29])
            begin
                paddr   = {dmw1[27:25], vaddr[28:0]};
                memType = dmw1[5:4];
            end
            // Upper half is kernel only.
            else if (crmd[1:0] != 2'd0 && vaddr[31])
            begin
                excp  = valid;
                ecode = `MMU_ECODE_ADE;
                esub  = (op == mmuPkg::FETCH) ? `MMU_ESUB_ADEF : `MMU_ESUB_ADEM;
            end
        end
    endfunction

    always_comb
    begin
        mapOne(reqValid[0], reqFlush[0], reqOp0, reqVaddr0,
               rawPaddr0, rawMemType0, rawExcp[0], rawEcode0, rawEsub0);
        mapOne(reqValid[1], reqFlush[1], reqOp1, reqVaddr1,
               rawPaddr1, rawMemType1, rawExcp[1], rawEcode1, rawEsub1);
    end

endmodule

// File: hw/translateStage.sv
`timescale 1ns/1ns
`include "mmu_defs.svh"

module translateStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   inValid,
    input  logic                   inExcp,
    input  logic [`MMU_ADDR_W-1:0] inVaddr,
    input  logic [`MMU_ADDR_W-1:0] inPaddr,
    input  logic [1:0]             inMemType,
    input  logic [5:0]             inEcode,
    input  logic [8:0]             inEsub,
    output logic                   outValid,
    output logic                   outExcp,
    output logic [`MMU_ADDR_W-1:0] outVaddr,
    output logic [`MMU_ADDR_W-1:0] outPaddr,
    output logic [1:0]             outMemType,
    output logic [5:0]             outEcode,
    output logic [8:0]             outEsub
);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid   <= 1'b0;
            outExcp    <= 1'b0;
            outVaddr   <= '0;
            outPaddr   <= '0;
            outMemType <= 2'd0;
            outEcode   <= 6'd0;
            outEsub    <= 9'd0;
        end
        else
        begin
            // Flush kills the slot even under stall.
            if (flush)
            begin
                outValid <= 1'b0;
                outExcp  <= 1'b0;
            end
            else if (!stall)
            begin
                outValid <= inValid;
                outExcp  <= inExcp;
            end
            if (!stall)
            begin
                outVaddr   <= inVaddr;
                outPaddr   <= inPaddr;
                outMemType <= inMemType;
                outEcode   <= inEcode;
                outEsub    <= inEsub;
            end
        end
    end

    // An exception only ever rides on a valid request.
    excpNeedsValid: assert property (
        @(posedge clk) disable iff (!rstN)
        outExcp |-> outValid
    ) else $error("stage exception without a valid request");

endmodule

// File: hw/excpRecorder.sv
`timescale 1ns/1ns
`include "mmu_defs.svh"

module excpRecorder (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   excpClear,
    input  logic                   excp0,
    input  logic                   excp1,
    input  logic [`MMU_ADDR_W-1:0] vaddr0,
    input  logic [`MMU_ADDR_W-1:0] vaddr1,
    input  logic [5:0]             ecode0,
    input  logic [5:0]             ecode1,
    input  logic [8:0]             esub0,
    input  logic [8:0]             esub1,
    output logic [`MMU_ADDR_W-1:0] badVaddr,
    output logic [5:0]             ecode,
    output logic [8:0]             esub,
    output logic                   excpPulse,
    output logic                   excpHeld
);

    mmuPkg::recState_e state;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state     <= mmuPkg::IDLE;
            badVaddr  <= '0;
            ecode     <= 6'd0;
            esub      <= 9'd0;
            excpPulse <= 1'b0;
        end
        else
        begin
            excpPulse <= 1'b0;
            case (state)
                mmuPkg::IDLE:
                begin
                    // Port 0 first.
                    if (excp0)
                    begin
                        badVaddr  <= vaddr0;
                        ecode     <= ecode0;
                        esub      <= esub0;
                        excpPulse <= 1'b1;
                        state     <= mmuPkg::HELD;
                    end
                    else if (excp1)
                    begin
                        badVaddr  <= vaddr1;
                        ecode     <= ecode1;
                        esub      <= esub1;
                        excpPulse <= 1'b1;
                        state     <= mmuPkg::HELD;
                    end
                end
                mmuPkg::HELD:
                begin
                    if (excpClear)
                        state <= mmuPkg::IDLE;
                end
            endcase
        end
    end

    assign excpHeld = (state == mmuPkg::HELD);

    pulseSingle: assert property (
        @(posedge clk) disable iff (!rstN)
        excpPulse |=> !excpPulse
    ) else $error("excpPulse high on consecutive cycles");

endmodule

// File: hw/mmuTop.sv
`timescale 1ns/1ns
`include "mmu_defs.svh"

module mmuTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   csrWe,
    input  mmuPkg::csrSel_e        csrSel,
    input  logic [`MMU_ADDR_W-1:0] csrWdata,
    input  logic                   reqValid0,
    input  logic                   reqValid1,
    input  mmuPkg::opType_e        reqOp0,
    input  mmuPkg::opType_e        reqOp1,
    input  logic [`MMU_ADDR_W-1:0] reqVaddr0,
    input  logic [`MMU_ADDR_W-1:0] reqVaddr1,
    input  logic                   stall0,
    input  logic                   stall1,
    input  logic                   flush0,
    input  logic                   flush1,
    input  logic                   excpClear,
    output logic [`MMU_ADDR_W-1:0] paddr0,
    output logic [`MMU_ADDR_W-1:0] paddr1,
    output logic [1:0]             memType0,
    output logic [1:0]             memType1,
    output logic                   valid0,
    output logic                   valid1,
    output logic                   excp0,
    output logic                   excp1,
    output logic [9:0]             asid,
    output logic [`MMU_ADDR_W-1:0] badVaddr,
    output logic [5:0]             ecode,
    output logic [8:0]             esub,
    output logic                   excpPulse,
    output logic                   excpHeld
);

    logic [8:0]             crmd;
    logic [`MMU_ADDR_W-1:0] dmw0;
    logic [`MMU_ADDR_W-1:0] dmw1;
    logic                   dmw0Ok;
    logic                   dmw1Ok;
    logic [`MMU_ADDR_W-1:0] rawPaddr0;
    logic [`MMU_ADDR_W-1:0] rawPaddr1;
    logic [1:0]             rawMemType0;
    logic [1:0]             rawMemType1;
    logic [`MMU_PORTS-1:0]  rawExcp;
    logic [5:0]             rawEcode0;
    logic [5:0]             rawEcode1;
    logic [8:0]             rawEsub0;
    logic [8:0]             rawEsub1;
    logic [`MMU_ADDR_W-1:0] stageVaddr0;
    logic [`MMU_ADDR_W-1:0] stageVaddr1;
    logic [5:0]             stageEcode0;
    logic [5:0]             stageEcode1;
    logic [8:0]             stageEsub0;
    logic [8:0]             stageEsub1;

    mapCsrRegs mapCsrRegs_inst (
        .clk      (clk),
        .rstN     (rstN),
        .csrWe    (csrWe),
        .csrSel   (csrSel),
        .csrWdata (csrWdata),
        .crmd     (crmd),
        .asid     (asid),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .dmw0Ok   (dmw0Ok),
        .dmw1Ok   (dmw1Ok)
    );

    // Flush also zeroes the raw result.
    addrTranslator addrTranslator_inst (
        .crmd        (crmd),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .dmw0Ok      (dmw0Ok),
        .dmw1Ok      (dmw1Ok),
        .reqValid    ({reqValid1, reqValid0}),
        .reqFlush    ({flush1, flush0}),
        .reqOp0      (reqOp0),
        .reqOp1      (reqOp1),
        .reqVaddr0   (reqVaddr0),
        .reqVaddr1   (reqVaddr1),
        .rawPaddr0   (rawPaddr0),
        .rawPaddr1   (rawPaddr1),
        .rawMemType0 (rawMemType0),
        .rawMemType1 (rawMemType1),
        .rawExcp     (rawExcp),
        .rawEcode0   (rawEcode0),
        .rawEcode1   (rawEcode1),
        .rawEsub0    (rawEsub0),
        .rawEsub1    (rawEsub1)
    );

    translateStage stage0_inst (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall0),
        .flush      (flush0),
        .inValid    (reqValid0),
        .inExcp     (rawExcp[0]),
        .inVaddr    (reqVaddr0),
        .inPaddr    (rawPaddr0),
        .inMemType  (rawMemType0),
        .inEcode    (rawEcode0),
        .inEsub     (rawEsub0),
        .outValid   (valid0),
        .outExcp    (excp0),
        .outVaddr   (stageVaddr0),
        .outPaddr   (paddr0),
        .outMemType (memType0),
        .outEcode   (stageEcode0),
        .outEsub    (stageEsub0)
    );

    translateStage stage1_inst (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall1),
        .flush      (flush1),
        .inValid    (reqValid1),
        .inExcp     (rawExcp[1]),
        .inVaddr    (reqVaddr1),
        .inPaddr    (rawPaddr1),
        .inMemType  (rawMemType1),
        .inEcode    (rawEcode1),
        .inEsub     (rawEsub1),
        .outValid   (valid1),
        .outExcp    (excp1),
        .outVaddr   (stageVaddr1),
        .outPaddr   (paddr1),
        .outMemType (memType1),
        .outEcode   (stageEcode1),
        .outEsub    (stageEsub1)
    );

    excpRecorder excpRecorder_inst (
        .clk       (clk),
        .rstN      (rstN),
        .excpClear (excpClear),
        .excp0     (excp0),
        .excp1     (excp1),
        .vaddr0    (stageVaddr0),
        .vaddr1    (stageVaddr1),
        .ecode0    (stageEcode0),
        .ecode1    (stageEcode1),
        .esub0     (stageEsub0),
        .esub1     (stageEsub1),
        .badVaddr  (badVaddr),
        .ecode     (ecode),
        .esub      (esub),
        .excpPulse (excpPulse),
        .excpHeld  (excpHeld)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod = 20;

    initial
    begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Four rising edges in reset, released on a falling edge.
    initial
    begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: bench/mmuTb.sv
`timescale 1ns/1ns

module mmuTb;

    localparam int     randCount = 16;
    localparam longint periodNs  = 40;
    // PLV0 windows for the random pass, VSEG 5 and VSEG 4.
    localparam logic [31:0] randWin0 = 32'hA000_0011;
    localparam logic [31:0] randWin1 = 32'h8200_0021;

    logic            clk;
    logic            rstN;
    logic            csrWe;
    mmuPkg::csrSel_e csrSel;
    logic [31:0]     csrWdata;
    logic            reqValid0;
    logic            reqValid1;
    mmuPkg::opType_e reqOp0;
    mmuPkg::opType_e reqOp1;
    logic [31:0]     reqVaddr0;
    logic [31:0]     reqVaddr1;
    logic            stall0;
    logic            stall1;
    logic            flush0;
    logic            flush1;
    logic            excpClear;
    logic [31:0]     paddr0;
    logic [31:0]     paddr1;
    logic [1:0]      memType0;
    logic [1:0]      memType1;
    logic            valid0;
    logic            valid1;
    logic            excp0;
    logic            excp1;
    logic [9:0]      asid;
    logic [31:0]     badVaddr;
    logic [5:0]      ecode;
    logic [8:0]      esub;
    logic            excpPulse;
    logic            excpHeld;
    int              fd;
    logic [31:0]     rngState;
    longint          limitNs;
    logic            limitReady;

    clockGen clockGen_inst (
        .clk  (clk),
        .rstN (rstN)
    );

    mmuTop mmuTop_inst (.*);

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // DMW0 is tried before DMW1.
    function automatic logic [31:0] hitWindow(input logic [31:0] va);
        if (va[31:29] == randWin0[31:29])
            return randWin0;
        return randWin1;
    endfunction

    task automatic idleInputs();
        csrWe     = 1'b0;
        excpClear = 1'b0;
        reqValid0 = 1'b0;
        reqValid1 = 1'b0;
    endtask

    task automatic advanceCycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic csrWrite(input logic [1:0] sel, input logic [31:0] data);
        idleInputs();
        csrWe    = 1'b1;
        csrSel   = mmuPkg::csrSel_e'(sel);
        csrWdata = data;
        advanceCycle();
    endtask

    task automatic sendRequest(input logic v0, input logic [1:0] op0, input logic [31:0] va0,
                               input logic v1, input logic [1:0] op1, input logic [31:0] va1);
        idleInputs();
        reqValid0 = v0;
        reqOp0    = mmuPkg::opType_e'(op0);
        reqVaddr0 = va0;
        reqValid1 = v1;
        reqOp1    = mmuPkg::opType_e'(op1);
        reqVaddr1 = va1;
        advanceCycle();
    endtask

    task automatic expectPorts(input logic [31:0] v0, pa0, mt0, ex0, v1, pa1, mt1, ex1);
        checkValue(32'(valid0), v0, "valid0");
        checkValue(paddr0, pa0, "paddr0");
        checkValue(32'(memType0), mt0, "memType0");
        checkValue(32'(excp0), ex0, "excp0");
        checkValue(32'(valid1), v1, "valid1");
        checkValue(paddr1, pa1, "paddr1");
        checkValue(32'(memType1), mt1, "memType1");
        checkValue(32'(excp1), ex1, "excp1");
    endtask

    task automatic runRandomWindows();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] va0;
        logic [31:0] va1;
        logic [31:0] w0;
        logic [31:0] w1;
        stall0 = 1'b0;
        stall1 = 1'b0;
        flush0 = 1'b0;
        flush1 = 1'b0;
        // Mapped mode at PLV0.
        csrWrite(2'd0, 32'h0000_0010);
        csrWrite(2'd2, randWin0);
        csrWrite(2'd3, randWin1);
        for (int i = 0; i < randCount; i++)
        begin
            rngState = xorshift(rngState);
            r0 = rngState;
            rngState = xorshift(rngState);
            r1 = rngState;
            va0 = {(r0[0] ? randWin0[31:29] : randWin1[31:29]), r0[31:3]};
            va1 = {(r1[0] ? randWin0[31:29] : randWin1[31:29]), r1[31:3]};
            w0 = hitWindow(va0);
            w1 = hitWindow(va1);
            sendRequest(1'b1, {1'b0, r0[1]}, va0, 1'b1, {1'b0, r1[1]}, va1);
            expectPorts(32'd1, {w0[27:25], va0[28:0]}, 32'(w0[5:4]), 32'd0,
                        32'd1, {w1[27:25], va1[28:0]}, 32'(w1[5:4]), 32'd0);
        end
    endtask

    initial
    begin
        wait (limitReady === 1'b1);
        #(limitNs);
        abortRun("Watchdog timeout: the simulation did not finish in time");
    end

    initial
    begin
        int          code;
        int          ch;
        int          lines;
        logic [7:0]  cmd;
        logic [31:0] f [0:14];
        logic        done;
        limitReady = 1'b0;
        csrSel     = mmuPkg::CRMD;
        csrWdata   = '0;
        reqOp0     = mmuPkg::FETCH;
        reqOp1     = mmuPkg::FETCH;
        reqVaddr0  = '0;
        reqVaddr1  = '0;
        stall0     = 1'b0;
        stall1     = 1'b0;
        flush0     = 1'b0;
        flush1     = 1'b0;
        idleInputs();
        rngState = 32'h9828;
        fd = $fopen("bench/mmu_stimulus.txt", "r");
        if (fd == 0)
            abortRun("Cannot open the stimulus file bench/mmu_stimulus.txt");
        // Line count sets the watchdog limit.
        lines = 0;
        ch = $fgetc(fd);
        while (ch != -1)
        begin
            if (ch == 10)
                lines++;
            ch = $fgetc(fd);
        end
        $fclose(fd);
        limitNs    = (lines + randCount + 20) * periodNs;
        limitReady = 1'b1;
        fd = $fopen("bench/mmu_stimulus.txt", "r");
        @(posedge rstN);
        @(negedge clk);
        done = 1'b0;
        while (!done)
        begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1)
                done = 1'b1;
            else if (cmd == "#")
            begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end
            else if (cmd == "W")
            begin
                code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                if (code != 3)
                    abortRun("Malformed CSR write line in the stimulus file");
                csrWrite(f[0][1:0], f[1]);
                checkValue(32'(asid), f[2], "asid");
            end
            else if (cmd == "R")
            begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                               f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                if (code != 15)
                    abortRun("Malformed request line in the stimulus file");
                sendRequest(f[0][0], f[1][1:0], f[2], f[3][0], f[4][1:0], f[5]);
                expectPorts(f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                checkValue(32'(excpPulse), f[14], "excpPulse");
            end
            else if (cmd == "S")
            begin
                code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                if (code != 4)
                    abortRun("Malformed stall/flush line in the stimulus file");
                stall0 = f[0][0];
                stall1 = f[1][0];
                flush0 = f[2][0];
                flush1 = f[3][0];
            end
            else if (cmd == "C")
            begin
                code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                if (code != 3)
                    abortRun("Malformed clear line in the stimulus file");
                // A clear always follows a capture.
                checkValue(32'(excpHeld), 32'd1, "excpHeld");
                idleInputs();
                excpClear = 1'b1;
                advanceCycle();
                checkValue(badVaddr, f[0], "badVaddr");
                checkValue(32'(ecode), f[1], "ecode");
                checkValue(32'(esub), f[2], "esub");
                checkValue(32'(excpHeld), 32'd0, "excpHeld");
            end
            else
                abortRun($sformatf("Unknown command '%c' in the stimulus file", cmd));
        end
        $fclose(fd);
        runRandomWindows();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: bench/mmu_stimulus.txt
# W sel data expAsid | S stall0 stall1 flush0 flush1 | C expBadVaddr expEcode expEsub
# R v0 op0 va0 v1 op1 va1 expV0 expPa0 expMt0 expEx0 expV1 expPa1 expMt1 expEx1 expPulse
W 0 00000128 000
W 1 0007FFA5 3A5
R 1 0 12345678 1 1 9ABCDEF0 1 12345678 1 0 1 9ABCDEF0 2 0 0
R 1 2 00001000 1 2 FFFF0000 1 00001000 2 0 1 FFFF0000 2 0 0
# Mapped mode at PLV0 with two windows.
W 0 00000010 3A5
W 2 93000111 3A5
W 3 A6000021 3A5
R 1 0 92345678 1 1 B0000004 1 32345678 1 0 1 70000004 2 0 0
R 1 0 00001234 1 1 E0000000 1 00000000 0 0 1 00000000 0 0 0
W 3 86000021 3A5
R 1 1 80000040 1 2 9FFFFFFC 1 20000040 1 0 1 3FFFFFFC 1 0 0
# PLV3, only DMW1 usable.
W 0 00000013 3A5
W 3 86000028 3A5
R 1 0 80000040 1 1 00000010 1 60000040 2 0 1 00000000 0 0 0
R 1 0 C0000000 1 1 F0000008 1 00000000 0 1 1 00000000 0 1 0
R 0 1 E0000000 0 0 00000000 0 00000000 0 0 0 00000000 0 0 1
R 0 0 00000000 1 1 A0000000 0 00000000 0 0 1 00000000 0 1 0
R 0 0 00000000 0 0 00000000 0 00000000 0 0 0 00000000 0 0 0
C C0000000 08 000
R 0 0 00000000 1 1 A0000000 0 00000000 0 0 1 00000000 0 1 0
R 0 0 00000000 0 0 00000000 0 00000000 0 0 0 00000000 0 0 1
C A0000000 08 001
R 1 0 80001000 1 1 80002000 1 60001000 2 0 1 60002000 2 0 0
S 1 0 0 0
R 1 0 80003000 1 1 80004000 1 60001000 2 0 1 60004000 2 0 0
R 0 0 80005000 0 1 80005000 1 60001000 2 0 0 60005000 2 0 0
S 0 0 0 1
R 1 0 80006000 1 1 80007000 1 60006000 2 0 0 00000000 0 0 0
S 0 0 1 0
R 1 0 C0000000 1 1 80008000 0 00000000 0 0 1 60008000 2 0 0
S 0 0 0 0
R 1 0 8000A000 0 0 00000000 1 6000A000 2 0 0 00000000 0 0 0
S 1 0 1 0
R 1 0 8000B000 0 0 00000000 0 6000A000 2 0 0 00000000 0 0 0
S 0 0 0 0
R 1 1 C0000004 0 0 00000000 1 00000000 0 1 0 00000000 0 0 0
R 0 0 00000000 0 0 00000000 0 00000000 0 0 0 00000000 0 0 1
C C0000004 08 001

// File: mmuSys.f
+incdir+hw
hw/mmuPkg.sv
hw/mapCsrRegs.sv
hw/addrTranslator.sv
hw/translateStage.sv
hw/excpRecorder.sv
hw/mmuTop.sv
bench/clockGen.sv
bench/mmuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f mmuSys.f --top-module mmuTb -o mmuSim

output=$(./obj_dir/mmuSim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"
then
    exit 0
else
    exit 1
fi
